/* filelist.f */
+incdir+tests
hdl/rename_pkg.sv
hdl/rename_dispatch.sv
hdl/reg_table.sv
hdl/rename_out.sv
hdl/rename_stage.sv
tests/tb_rename_stage.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_rename_stage
out=$(./obj_dir/Vtb_rename_stage)
echo "$out"

if echo "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1

/* tests/tb_rename_model.svh */
// reference state of the rename stage
rat_entry_t m_spec [NUM_AREG];
rat_entry_t m_commit [NUM_AREG];
word_t m_arf [NUM_AREG];
rob_id_t m_ptr;
int m_cnt;
logic m_avail;

// expected output register
logic [1:0] m_out_slot_valid;
word_t m_out_pc;
areg_t [1:0] m_out_dst_areg;
rob_id_t [1:0] m_out_dst_robid;
logic [1:0] m_out_dst_check;
rob_id_t [3:0] m_out_src_robid;
word_t [3:0] m_out_src_data;
logic [3:0] m_out_src_ready;

// in-flight destinations, {wen, areg, check, robid}
logic [12:0] rob_q [$];

function automatic logic retire_writes(input int p);
    return retire[p] & retire_wen[p] & (retire_areg[p] != '0);
endfunction

// committed table with same-cycle retire bypass, port 1 last
function automatic rat_entry_t commit_read(input areg_t a);
    rat_entry_t v;
    v = m_commit[a];
    for (int p = 0; p < 2; p++) begin
        if (retire_writes(p) && retire_areg[p] == a) begin
            v = {retire_check[p], retire_robid[p]};
        end
    end
    return v;
endfunction

function automatic word_t arf_read(input areg_t a);
    word_t v;
    v = m_arf[a];
    for (int p = 0; p < 2; p++) begin
        if (retire_writes(p) && retire_areg[p] == a) begin
            v = retire_data[p];
        end
    end
    return v;
endfunction

function automatic logic model_in_ready();
    return m_avail & ~flush & out_ready;
endfunction

task automatic clear_outputs();
    m_out_slot_valid = '0;
    m_out_pc = '0;
    m_out_dst_areg = '0;
    m_out_dst_robid = '0;
    m_out_dst_check = '0;
    m_out_src_robid = '0;
    m_out_src_data = '0;
    m_out_src_ready = '0;
endtask

task automatic model_reset();
    for (int i = 0; i < NUM_AREG; i++) begin
        m_spec[i] = '0;
        m_commit[i] = '0;
        m_arf[i] = '0;
    end
    m_ptr = '0;
    m_cnt = 0;
    m_avail = 1'b1;
    clear_outputs();
    rob_q.delete();
endtask

// one clock edge with the inputs as they are held now
task automatic model_step();
    logic [1:0] iss;
    logic [1:0] nchk;
    rob_id_t [1:0] rid;
    rat_entry_t [3:0] ssrc;
    rat_entry_t cd;
    logic [3:0] rdy;
    word_t [3:0] sdata;
    int nis;
    int nre;
    iss = slot_valid & {2{in_valid & model_in_ready()}};
    rid[0] = m_ptr;
    rid[1] = iss[0] ? m_ptr + 6'd1 : m_ptr;
    for (int i = 0; i < 2; i++) begin
        cd = commit_read(dst_areg[i]);
        nchk[i] = ~cd[CHECK_BIT];
    end
    for (int j = 0; j < 4; j++) begin
        ssrc[j] = m_spec[src_areg[j]];
        rdy[j] = ~src_need[j] | (ssrc[j] == commit_read(src_areg[j]));
        sdata[j] = arf_read(src_areg[j]);
    end
    nis = int'(iss[0]) + int'(iss[1]);
    nre = int'(retire[0]) + int'(retire[1]);
    for (int p = 0; p < 2; p++) begin
        if (retire_writes(p)) begin
            m_arf[retire_areg[p]] = retire_data[p];
        end
    end
    if (flush) begin
        for (int i = 0; i < NUM_AREG; i++) begin
            m_spec[i] = '0;
            m_commit[i] = '0;
        end
        m_ptr = '0;
        m_cnt = 0;
        m_avail = 1'b1;
        clear_outputs();
    end else begin
        if (out_ready) begin
            m_out_slot_valid = iss;
            m_out_pc = pc;
            m_out_dst_areg = dst_areg;
            m_out_dst_robid = rid;
            m_out_dst_check = nchk;
            for (int j = 0; j < 4; j++) begin
                m_out_src_robid[j] = ssrc[j][ROB_ID_W-1:0];
            end
            m_out_src_data = sdata;
            m_out_src_ready = rdy;
        end
        for (int i = 0; i < 2; i++) begin
            if (iss[i]) begin
                rob_q.push_back({dst_wen[i], dst_areg[i], nchk[i], rid[i]});
            end
            if (iss[i] && dst_wen[i] && dst_areg[i] != '0) begin
                m_spec[dst_areg[i]] = {nchk[i], rid[i]};
            end
        end
        for (int p = 0; p < 2; p++) begin
            if (retire_writes(p)) begin
                m_commit[retire_areg[p]] = {retire_check[p], retire_robid[p]};
            end
        end
        m_avail = (m_cnt <= ROB_DEPTH - 4);
        m_cnt = m_cnt + nis - nre;
        m_ptr = m_ptr + 6'(nis);
    end
endtask

/* tests/tb_rename_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rename_stage;

    import rename_pkg::*;

    localparam int ROB_DEPTH = 64;
    localparam int NUM_CYCLES = 4000;
    localparam int MAX_WAIT = 20000;

    logic clk;
    logic rst_n;
    logic flush;
    logic in_valid;
    logic [1:0] slot_valid;
    areg_t [3:0] src_areg;
    logic [3:0] src_need;
    areg_t [1:0] dst_areg;
    logic [1:0] dst_wen;
    word_t pc;
    logic [1:0] retire;
    logic [1:0] retire_wen;
    areg_t [1:0] retire_areg;
    rob_id_t [1:0] retire_robid;
    logic [1:0] retire_check;
    word_t [1:0] retire_data;
    logic out_ready;

    logic in_ready_o;
    logic [1:0] out_slot_valid_o;
    word_t out_pc_o;
    areg_t [1:0] out_dst_areg_o;
    rob_id_t [1:0] out_dst_robid_o;
    logic [1:0] out_dst_check_o;
    rob_id_t [3:0] out_src_robid_o;
    word_t [3:0] out_src_data_o;
    logic [3:0] out_src_ready_o;

    integer seed = 32'ha11cc81d;
    int cycle;
    int value_errors;
    int other_errors;
    int stall_seen;

    `include "tb_rename_model.svh"

    rename_stage #(
        .ROB_DEPTH (ROB_DEPTH)
    ) dut (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .flush_i          (flush),
        .in_valid_i       (in_valid),
        .in_ready_o       (in_ready_o),
        .slot_valid_i     (slot_valid),
        .src_areg_i       (src_areg),
        .src_need_i       (src_need),
        .dst_areg_i       (dst_areg),
        .dst_wen_i        (dst_wen),
        .pc_i             (pc),
        .retire_i         (retire),
        .retire_wen_i     (retire_wen),
        .retire_areg_i    (retire_areg),
        .retire_robid_i   (retire_robid),
        .retire_check_i   (retire_check),
        .retire_data_i    (retire_data),
        .out_ready_i      (out_ready),
        .out_slot_valid_o (out_slot_valid_o),
        .out_pc_o         (out_pc_o),
        .out_dst_areg_o   (out_dst_areg_o),
        .out_dst_robid_o  (out_dst_robid_o),
        .out_dst_check_o  (out_dst_check_o),
        .out_src_robid_o  (out_src_robid_o),
        .out_src_data_o   (out_src_data_o),
        .out_src_ready_o  (out_src_ready_o)
    );

    always #10 clk = ~clk;

    task automatic check_field(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic drive_idle();
        flush <= 1'b0;
        in_valid <= 1'b0;
        slot_valid <= '0;
        retire <= '0;
        out_ready <= 1'b0;
    endtask

    task automatic drive_stimulus();
        logic [31:0] r;
        logic [12:0] e;
        logic flush_now;
        logic withhold;
        logic [1:0] ret;
        logic [1:0] rwen;
        areg_t [1:0] ra;
        rob_id_t [1:0] rid;
        logic [1:0] rchk;
        word_t [1:0] rdata;
        r = $random(seed);
        flush_now = (r[6:0] == 7'd0);
        // long windows without retirement fill the buffer
        withhold = ((cycle % 400) >= 200) && ((cycle % 400) < 320);
        flush <= flush_now;
        in_valid <= (r[9:8] != 2'b00);
        slot_valid <= r[11:10] | {1'b0, r[12]};
        out_ready <= (r[15:13] != 3'b000);
        dst_wen <= r[17:16] | {r[18], 1'b0};
        dst_areg <= r[28:19];
        r = $random(seed);
        src_areg <= r[19:0];
        src_need <= r[23:20];
        pc <= $random(seed);
        ret = '0;
        rwen = '0;
        ra = '0;
        rid = '0;
        rchk = '0;
        rdata = '0;
        if (flush_now) begin
            rob_q.delete();
        end else if (!withhold) begin
            for (int k = 0; k < 2; k++) begin
                r = $random(seed);
                if (rob_q.size() > 0 && r[1:0] != 2'b00 && (k == 0 || ret[0])) begin
                    e = rob_q.pop_front();
                    ret[k] = 1'b1;
                    {rwen[k], ra[k], rchk[k], rid[k]} = e;
                end
                rdata[k] = $random(seed);
            end
        end
        retire <= ret;
        retire_wen <= rwen;
        retire_areg <= ra;
        retire_robid <= rid;
        retire_check <= rchk;
        retire_data <= rdata;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            model_reset();
            drive_idle();
        end else begin
            model_step();
            drive_stimulus();
        end
        cycle++;
    end

    // outputs are stable half a cycle after the edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_field("in_ready_o", 128'(in_ready_o), 128'(model_in_ready()));
            check_field("out_slot_valid_o", 128'(out_slot_valid_o), 128'(m_out_slot_valid));
            check_field("out_pc_o", 128'(out_pc_o), 128'(m_out_pc));
            check_field("out_dst_areg_o", 128'(out_dst_areg_o), 128'(m_out_dst_areg));
            check_field("out_dst_robid_o", 128'(out_dst_robid_o), 128'(m_out_dst_robid));
            check_field("out_dst_check_o", 128'(out_dst_check_o), 128'(m_out_dst_check));
            check_field("out_src_robid_o", 128'(out_src_robid_o), 128'(m_out_src_robid));
            check_field("out_src_data_o", 128'(out_src_data_o), 128'(m_out_src_data));
            check_field("out_src_ready_o", 128'(out_src_ready_o), 128'(m_out_src_ready));
            if (out_ready && !flush && !in_ready_o) begin
                stall_seen++;
            end
        end
    end

    initial begin
        int guard;
        clk = 1'b0;
        rst_n = 1'b0;
        flush = 1'b0;
        in_valid = 1'b0;
        slot_valid = '0;
        src_areg = '0;
        src_need = '0;
        dst_areg = '0;
        dst_wen = '0;
        pc = '0;
        retire = '0;
        retire_wen = '0;
        retire_areg = '0;
        retire_robid = '0;
        retire_check = '0;
        retire_data = '0;
        out_ready = 1'b0;
        cycle = 0;
        value_errors = 0;
        other_errors = 0;
        stall_seen = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        guard = 0;
        while (cycle < NUM_CYCLES && guard < MAX_WAIT) begin
            @(posedge clk);
            guard++;
        end
        if (cycle < NUM_CYCLES) begin
            $display("timeout: the run did not reach its last cycle");
            other_errors++;
        end
        assert (stall_seen > 0) else begin
            $display("in_ready_o never dropped for a full reorder buffer");
            other_errors++;
        end
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/rename_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module rename_stage #(
    parameter int unsigned ROB_DEPTH = 64
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            flush_i,
    // decode side
    input  logic                            in_valid_i,
    output logic                            in_ready_o,
    input  logic [1:0]                      slot_valid_i,
    input  rename_pkg::areg_t [3:0]         src_areg_i,
    input  logic [3:0]                      src_need_i,
    input  rename_pkg::areg_t [1:0]         dst_areg_i,
    input  logic [1:0]                      dst_wen_i,
    input  rename_pkg::word_t               pc_i,
    // commit side
    input  logic [1:0]                      retire_i,
    input  logic [1:0]                      retire_wen_i,
    input  rename_pkg::areg_t [1:0]         retire_areg_i,
    input  rename_pkg::rob_id_t [1:0]       retire_robid_i,
    input  logic [1:0]                      retire_check_i,
    input  rename_pkg::word_t [1:0]         retire_data_i,
    // issue side
    input  logic                            out_ready_i,
    output logic [1:0]                      out_slot_valid_o,
    output rename_pkg::word_t               out_pc_o,
    output rename_pkg::areg_t [1:0]         out_dst_areg_o,
    output rename_pkg::rob_id_t [1:0]       out_dst_robid_o,
    output logic [1:0]                      out_dst_check_o,
    output rename_pkg::rob_id_t [3:0]       out_src_robid_o,
    output rename_pkg::word_t [3:0]         out_src_data_o,
    output logic [3:0]                      out_src_ready_o
);

    import rename_pkg::*;

    logic [1:0]         issue;
    rob_id_t [1:0]      dst_robid;
    logic [1:0]         rat_we;
    logic [1:0]         new_check;
    rat_entry_t [1:0]   spec_wdata;
    rat_entry_t [3:0]   spec_src_entry;
    logic [1:0]         commit_we;
    rat_entry_t [1:0]   commit_wdata;
    rat_entry_t [5:0]   commit_rdata;
    rat_entry_t [3:0]   commit_src_entry;
    rat_entry_t [1:0]   commit_dst_entry;
    word_t [3:0]        arf_rdata;

    for (genvar i = 0; i < 2; i++) begin : g_write
        assign spec_wdata[i]   = {new_check[i], dst_robid[i]};
        assign commit_we[i]    = retire_i[i] & retire_wen_i[i] & (retire_areg_i[i] != '0);
        assign commit_wdata[i] = {retire_check_i[i], retire_robid_i[i]};
    end

    // sources on ports 0-3, destinations on 4-5
    assign commit_src_entry = commit_rdata[3:0];
    assign commit_dst_entry = commit_rdata[5:4];

    rename_dispatch #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_dispatch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .in_valid_i   (in_valid_i),
        .slot_valid_i (slot_valid_i),
        .dst_areg_i   (dst_areg_i),
        .dst_wen_i    (dst_wen_i),
        .retire_i     (retire_i),
        .out_ready_i  (out_ready_i),
        .in_ready_o   (in_ready_o),
        .issue_o      (issue),
        .dst_robid_o  (dst_robid),
        .rat_we_o     (rat_we)
    );

    reg_table #(
        .DATA_W         (RAT_W),
        .R_PORTS        (4),
        .FORWARD        (1'b0),
        .CLEAR_ON_FLUSH (1'b1)
    ) spec_rat (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .raddr_i (src_areg_i),
        .rdata_o (spec_src_entry),
        .waddr_i (dst_areg_i),
        .we_i    (rat_we),
        .wdata_i (spec_wdata)
    );

    reg_table #(
        .DATA_W         (RAT_W),
        .R_PORTS        (6),
        .FORWARD        (1'b1),
        .CLEAR_ON_FLUSH (1'b1)
    ) commit_rat (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .raddr_i ({dst_areg_i, src_areg_i}),
        .rdata_o (commit_rdata),
        .waddr_i (retire_areg_i),
        .we_i    (commit_we),
        .wdata_i (commit_wdata)
    );

    // register values survive a flush
    reg_table #(
        .DATA_W         (WORD_W),
        .R_PORTS        (4),
        .FORWARD        (1'b1),
        .CLEAR_ON_FLUSH (1'b0)
    ) arf (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .raddr_i (src_areg_i),
        .rdata_o (arf_rdata),
        .waddr_i (retire_areg_i),
        .we_i    (commit_we),
        .wdata_i (retire_data_i)
    );

    rename_out u_out (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .out_ready_i      (out_ready_i),
        .issue_i          (issue),
        .pc_i             (pc_i),
        .dst_areg_i       (dst_areg_i),
        .dst_robid_i      (dst_robid),
        .src_need_i       (src_need_i),
        .spec_src_i       (spec_src_entry),
        .commit_src_i     (commit_src_entry),
        .commit_dst_i     (commit_dst_entry),
        .src_data_i       (arf_rdata),
        .new_check_o      (new_check),
        .out_slot_valid_o (out_slot_valid_o),
        .out_pc_o         (out_pc_o),
        .out_dst_areg_o   (out_dst_areg_o),
        .out_dst_robid_o  (out_dst_robid_o),
        .out_dst_check_o  (out_dst_check_o),
        .out_src_robid_o  (out_src_robid_o),
        .out_src_data_o   (out_src_data_o),
        .out_src_ready_o  (out_src_ready_o)
    );

endmodule

`default_nettype wire

/* hdl/rename_out.sv */
`timescale 1ns/1ns
`default_nettype none

module rename_out (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            flush_i,
    input  logic                            out_ready_i,
    input  logic [1:0]                      issue_i,
    input  rename_pkg::word_t               pc_i,
    input  rename_pkg::areg_t [1:0]         dst_areg_i,
    input  rename_pkg::rob_id_t [1:0]       dst_robid_i,
    input  logic [3:0]                      src_need_i,
    input  rename_pkg::rat_entry_t [3:0]    spec_src_i,
    input  rename_pkg::rat_entry_t [3:0]    commit_src_i,
    input  rename_pkg::rat_entry_t [1:0]    commit_dst_i,
    input  rename_pkg::word_t [3:0]         src_data_i,
    output logic [1:0]                      new_check_o,
    output logic [1:0]                      out_slot_valid_o,
    output rename_pkg::word_t               out_pc_o,
    output rename_pkg::areg_t [1:0]         out_dst_areg_o,
    output rename_pkg::rob_id_t [1:0]       out_dst_robid_o,
    output logic [1:0]                      out_dst_check_o,
    output rename_pkg::rob_id_t [3:0]       out_src_robid_o,
    output rename_pkg::word_t [3:0]         out_src_data_o,
    output logic [3:0]                      out_src_ready_o
);

    import rename_pkg::*;

    logic [3:0] src_ready;

    // flip the generation of the committed mapping
    for (genvar i = 0; i < 2; i++) begin : g_new_check
        assign new_check_o[i] = ~commit_dst_i[i][CHECK_BIT];
    end

    // same entry in both tables means the writer has retired
    for (genvar i = 0; i < 4; i++) begin : g_src_ready
        assign src_ready[i] = ~src_need_i[i] | (spec_src_i[i] == commit_src_i[i]);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            out_slot_valid_o <= '0;
            out_pc_o         <= '0;
            out_dst_areg_o   <= '0;
            out_dst_robid_o  <= '0;
            out_dst_check_o  <= '0;
            out_src_robid_o  <= '0;
            out_src_data_o   <= '0;
            out_src_ready_o  <= '0;
        end else if (out_ready_i) begin
            out_slot_valid_o <= issue_i;
            out_pc_o         <= pc_i;
            out_dst_areg_o   <= dst_areg_i;
            out_dst_robid_o  <= dst_robid_i;
            out_dst_check_o  <= new_check_o;
            for (int i = 0; i < 4; i++) begin
                out_src_robid_o[i] <= spec_src_i[i][ROB_ID_W-1:0];
            end
            out_src_data_o   <= src_data_i;
            out_src_ready_o  <= src_ready;
        end
    end

endmodule

`default_nettype wire

/* hdl/reg_table.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_table #(
    parameter int unsigned DATA_W         = 7,
    parameter int unsigned R_PORTS        = 4,
    parameter bit          FORWARD        = 1'b0,
    parameter bit          CLEAR_ON_FLUSH = 1'b0
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  rename_pkg::areg_t [R_PORTS-1:0]     raddr_i,
    output logic [R_PORTS-1:0][DATA_W-1:0]      rdata_o,
    input  rename_pkg::areg_t [1:0]             waddr_i,
    input  logic [1:0]                          we_i,
    input  logic [1:0][DATA_W-1:0]              wdata_i
);

    import rename_pkg::*;

    logic [DATA_W-1:0] mem_q [NUM_AREG];

    // port 1 is written last, so it wins on a shared address
    always_ff @(posedge clk) begin
        if (!rst_n_i || (CLEAR_ON_FLUSH && flush_i)) begin
            for (int i = 0; i < NUM_AREG; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (we_i[p]) begin
                    mem_q[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    // async read, optional bypass of this cycle's writes
    always_comb begin
        for (int r = 0; r < R_PORTS; r++) begin
            rdata_o[r] = mem_q[raddr_i[r]];
            if (FORWARD) begin
                for (int p = 0; p < 2; p++) begin
                    if (we_i[p] && (waddr_i[p] == raddr_i[r])) begin
                        rdata_o[r] = wdata_i[p];
                    end
                end
            end
        end
    end

    // callers must filter out r0 before writing
    a_no_zero_write: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(we_i[0] && (waddr_i[0] == '0)) && !(we_i[1] && (waddr_i[1] == '0))
    );

endmodule

`default_nettype wire

/* hdl/rename_dispatch.sv */
`timescale 1ns/1ns
`default_nettype none

module rename_dispatch #(
    parameter int unsigned ROB_DEPTH = 64
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        in_valid_i,
    input  logic [1:0]                  slot_valid_i,
    input  rename_pkg::areg_t [1:0]     dst_areg_i,
    input  logic [1:0]                  dst_wen_i,
    input  logic [1:0]                  retire_i,
    input  logic                        out_ready_i,
    output logic                        in_ready_o,
    output logic [1:0]                  issue_o,
    output rename_pkg::rob_id_t [1:0]   dst_robid_o,
    output logic [1:0]                  rat_we_o
);

    import rename_pkg::*;

    // one extra bit so a full buffer still fits
    localparam int unsigned CNT_W = ROB_ID_W + 1;

    rob_id_t            ptr_q;
    logic [CNT_W-1:0]   cnt_q;
    logic               avail_q;
    logic               grant;
    logic [1:0]         n_issue;
    logic [1:0]         n_retire;

    // availability is a cycle behind the count
    assign in_ready_o = avail_q & ~flush_i & out_ready_i;
    assign grant      = in_valid_i & in_ready_o;
    assign issue_o    = slot_valid_i & {2{grant}};

    // slot 1 takes the next id only if slot 0 used one
    assign dst_robid_o[0] = ptr_q;
    assign dst_robid_o[1] = issue_o[0] ? ptr_q + rob_id_t'(1) : ptr_q;

    for (genvar i = 0; i < 2; i++) begin : g_rat_we
        assign rat_we_o[i] = issue_o[i] & dst_wen_i[i] & (dst_areg_i[i] != '0);
    end

    assign n_issue  = {1'b0, issue_o[0]} + {1'b0, issue_o[1]};
    assign n_retire = {1'b0, retire_i[0]} + {1'b0, retire_i[1]};

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            ptr_q   <= '0;
            cnt_q   <= '0;
            avail_q <= 1'b1;
        end else begin
            ptr_q   <= ptr_q + rob_id_t'(n_issue);
            cnt_q   <= cnt_q + CNT_W'(n_issue) - CNT_W'(n_retire);
            // leave room for two more groups in flight
            avail_q <= (cnt_q <= CNT_W'(ROB_DEPTH - 4));
        end
    end

    // late availability must still keep the buffer from overflowing
    a_occupancy_bound: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        cnt_q <= CNT_W'(ROB_DEPTH)
    );

    // no speculative mapping may survive into a flushed table
    a_no_rename_on_flush: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        flush_i |-> (rat_we_o == 2'b00)
    );

endmodule

`default_nettype wire

/* hdl/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    // architectural register file
    localparam int unsigned AREG_W   = 5;
    localparam int unsigned NUM_AREG = 32;

    // reorder buffer ids wrap modulo 64
    localparam int unsigned ROB_ID_W = 6;

    // alias entry is {check, robid}
    localparam int unsigned RAT_W     = ROB_ID_W + 1;
    localparam int unsigned CHECK_BIT = ROB_ID_W;

    // data and pc width
    localparam int unsigned WORD_W = 32;

    // architectural register index, register 0 never written
    typedef logic [AREG_W-1:0] areg_t;

    // reorder buffer id
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // generation bit on top, rob id below
    typedef logic [RAT_W-1:0] rat_entry_t;

    // data word, also the pc
    typedef logic [WORD_W-1:0] word_t;

endpackage

`default_nettype wire
